/* vlog.f */
cache_geom_pkg.sv
mem_proto_pkg.sv
rsp_buf_if.sv
fifo_reg.sv
miss_req_sender.sv
refill_rsp_buffer.sv
refill_ctrl.sv
miss_handler.sv
tb_miss_handler.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the miss handler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_miss_handler -f vlog.f

status=0
./obj_dir/Vtb_miss_handler > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TB PASSED" sim.log; then
    exit 1
fi
exit 0

/* tb_miss_handler.sv */
// Miss handler testbench
`timescale 1ns/1ps
`default_nettype none

module tb_miss_handler
    import cache_geom_pkg::*;
    import mem_proto_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int RST_CYCLES  = 16;
    localparam int NTESTS      = 6;
    localparam int TEST_CYCLES = 200;

    logic                      clk;
    logic                      rst_n;
    logic                      miss_valid [NBANKS];
    logic                      miss_ready [NBANKS];
    nline_t                    miss_nline [NBANKS];
    tid_t                      miss_tid   [NBANKS];
    logic                      mem_req_valid;
    logic                      mem_req_ready;
    logic [MEM_ADDR_W-1:0]     mem_req_addr;
    logic [$bits(MEM_LEN)-1:0] mem_req_len;
    logic [MEM_ID_W-1:0]       mem_req_id;
    logic                      rsp_valid;
    logic                      rsp_ready;
    logic [MEM_DATA_W-1:0]     rsp_data;
    logic                      rsp_last;
    mem_err_e                  rsp_err;
    logic [MEM_ID_W-1:0]       rsp_id;
    logic                      rsp_inval;
    nline_t                    rsp_inval_nline;
    logic                      refill_req_valid;
    logic                      refill_req_ready;
    logic                      refill_busy;
    logic                      refill_is_error;
    logic                      refill_write_data;
    logic [MEM_DATA_W-1:0]     refill_data;
    chunk_idx_t                refill_word;
    logic                      refill_write_dir;
    logic                      inval_check_dir;
    nline_t                    inval_nline;
    logic                      inval_hit;
    logic                      inval_write_dir;
    logic                      mshr_ack    [NBANKS];
    tid_t                      mshr_ack_id [NBANKS];

    int                    seed = 7;
    string                 test_name;
    int                    err_cnt;
    int                    test_err0;
    int                    pass_cnt;
    int                    fail_cnt;
    int                    test_no;
    // Event counters kept by the compare process
    int                    n_ack;
    int                    n_wr;
    int                    n_dir;
    int                    n_chk;
    int                    n_iwr;
    int                    cyc;
    int                    chk_cyc;
    int                    exp_ack_bank;
    tid_t                  exp_ack_tid;
    logic                  exp_err;
    nline_t                exp_inval_nline;
    logic [MEM_DATA_W-1:0] exp_chunks [$];

    miss_handler i_dut (
        .clk_i (clk), .rst_ni (rst_n),
        .miss_req_valid_i (miss_valid), .miss_req_ready_o (miss_ready),
        .miss_req_nline_i (miss_nline), .miss_req_tid_i (miss_tid),
        .mem_req_valid_o (mem_req_valid), .mem_req_ready_i (mem_req_ready),
        .mem_req_addr_o (mem_req_addr), .mem_req_len_o (mem_req_len),
        .mem_req_id_o (mem_req_id),
        .mem_rsp_valid_i (rsp_valid), .mem_rsp_ready_o (rsp_ready),
        .mem_rsp_data_i (rsp_data), .mem_rsp_last_i (rsp_last),
        .mem_rsp_err_i (rsp_err), .mem_rsp_id_i (rsp_id),
        .mem_rsp_inval_i (rsp_inval), .mem_rsp_inval_nline_i (rsp_inval_nline),
        .refill_req_valid_o (refill_req_valid), .refill_req_ready_i (refill_req_ready),
        .refill_busy_o (refill_busy), .refill_is_error_o (refill_is_error),
        .refill_write_data_o (refill_write_data), .refill_data_o (refill_data),
        .refill_word_o (refill_word), .refill_write_dir_o (refill_write_dir),
        .inval_check_dir_o (inval_check_dir), .inval_nline_o (inval_nline),
        .inval_hit_i (inval_hit), .inval_write_dir_o (inval_write_dir),
        .mshr_ack_o (mshr_ack), .mshr_ack_id_o (mshr_ack_id)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Expected memory address and id: line then zero offset, bank then tid
    function automatic logic [MEM_ADDR_W+MEM_ID_W-1:0] exp_mem_fields(
        input int bank, input nline_t nline, input tid_t tid);
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_ID_W-1:0]   id;
        addr = MEM_ADDR_W'(nline) << LINE_OFFSET_W;
        id   = (MEM_ID_W'(bank) << TID_W) | MEM_ID_W'(tid);
        return {addr, id};
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("mismatch %s %s: expected 0x%0h actual 0x%0h",
                     test_name, what, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("error in %s: %s", test_name, msg);
        err_cnt++;
    endtask

    // Compare process, samples DUT outputs on the falling edge
    always @(negedge clk) begin
        cyc++;
        if (rst_n) begin
            for (int b = 0; b < NBANKS; b++) begin
                if (mshr_ack[b]) begin
                    n_ack++;
                    check_val("ack bank", exp_ack_bank, b);
                    check_val("ack tid", exp_ack_tid, mshr_ack_id[b]);
                    check_val("data writes before ack", 0, n_wr);
                end
            end
            if (refill_write_data) begin
                if (exp_chunks.size() == 0) begin
                    report_error("cache data written with no chunk expected");
                end else begin
                    check_val("chunk data", exp_chunks.pop_front(), refill_data);
                end
                check_val("chunk index", n_wr % CHUNKS, refill_word);
                n_wr++;
            end
            if (refill_write_dir) begin
                n_dir++;
                check_val("directory write chunk", CHUNKS - 1, refill_word);
                check_val("error flag", exp_err, refill_is_error);
            end
            if (inval_check_dir) begin
                n_chk++;
                chk_cyc = cyc;
                check_val("invalidation line", exp_inval_nline, inval_nline);
            end
            if (inval_write_dir) begin
                n_iwr++;
                check_val("invalidation write cycle", chk_cyc + 1, cyc);
            end
        end
    end

    task automatic start_test(input string name);
        test_no++;
        test_name = name;
        test_err0 = err_cnt;
        n_ack = 0;
        n_wr = 0;
        n_dir = 0;
        n_chk = 0;
        n_iwr = 0;
        exp_chunks.delete();
    endtask

    task automatic end_test();
        if (err_cnt == test_err0) begin
            pass_cnt++;
            $display("test %0d %s: ok", test_no, test_name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: failed with %0d errors", test_no, test_name,
                     err_cnt - test_err0);
        end
    endtask

    task automatic check_counts(input int ack, input int wr, input int dir,
                                input int chk, input int iwr);
        check_val("mshr ack count", ack, n_ack);
        check_val("data write count", wr, n_wr);
        check_val("directory write count", dir, n_dir);
        check_val("directory check count", chk, n_chk);
        check_val("invalidation write count", iwr, n_iwr);
        check_val("chunks left over", 0, exp_chunks.size());
    endtask

    // Waits for a request, holds ready low for some cycles, then accepts it
    task automatic take_mem_req(input int bank, input nline_t nline, input tid_t tid,
                                input int stall);
        logic [MEM_ADDR_W+MEM_ID_W-1:0] exp_f;
        exp_f = exp_mem_fields(bank, nline, tid);
        do @(negedge clk); while (!mem_req_valid);
        check_val("request address", exp_f[MEM_ADDR_W+MEM_ID_W-1 -: MEM_ADDR_W], mem_req_addr);
        check_val("request id", exp_f[MEM_ID_W-1:0], mem_req_id);
        check_val("request length", 3, mem_req_len);
        repeat (stall) begin
            @(negedge clk);
            check_val("valid under stall", 1, mem_req_valid);
            check_val("address under stall", exp_f[MEM_ADDR_W+MEM_ID_W-1 -: MEM_ADDR_W],
                      mem_req_addr);
            check_val("id under stall", exp_f[MEM_ID_W-1:0], mem_req_id);
        end
        @(posedge clk);
        mem_req_ready <= 1'b1;
        @(posedge clk);
        mem_req_ready <= 1'b0;
    endtask

    task automatic send_refill(input int bank, input tid_t tid, input mem_err_e err);
        logic [MEM_DATA_W-1:0] beat;
        exp_ack_bank = bank;
        exp_ack_tid  = tid;
        exp_err      = (err == MEM_NOK);
        for (int i = 0; i < CHUNKS; i++) begin
            beat = {$random(seed), $random(seed)};
            if (err == MEM_OK) exp_chunks.push_back(beat);
            @(posedge clk);
            rsp_valid <= 1'b1;
            rsp_data  <= beat;
            rsp_last  <= (i == CHUNKS - 1);
            rsp_err   <= err;
            rsp_id    <= {BANK_W'(bank), tid};
            do @(negedge clk); while (!rsp_ready);
        end
        @(posedge clk);
        rsp_valid <= 1'b0;
        rsp_last  <= 1'b0;
    endtask

    task automatic send_inval(input nline_t nline, input logic hit);
        exp_inval_nline = nline;
        @(posedge clk);
        rsp_valid       <= 1'b1;
        rsp_inval       <= 1'b1;
        rsp_last        <= 1'b1;
        rsp_inval_nline <= nline;
        inval_hit       <= hit;
        do @(negedge clk); while (!rsp_ready);
        @(posedge clk);
        rsp_valid <= 1'b0;
        rsp_inval <= 1'b0;
        rsp_last  <= 1'b0;
    endtask

    task automatic wait_idle();
        do @(negedge clk); while (refill_busy || refill_req_valid);
    endtask

    initial begin
        for (int b = 0; b < NBANKS; b++) begin
            miss_valid[b] = 1'b0;
            miss_nline[b] = '0;
            miss_tid[b]   = '0;
        end
        mem_req_ready    = 1'b0;
        rsp_valid        = 1'b0;
        rsp_data         = '0;
        rsp_last         = 1'b0;
        rsp_err          = MEM_OK;
        rsp_id           = '0;
        rsp_inval        = 1'b0;
        rsp_inval_nline  = '0;
        refill_req_ready = 1'b1;
        inval_hit        = 1'b0;
        rst_n            = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        start_test("single miss");
        @(negedge clk);
        check_val("request valid after reset", 0, mem_req_valid);
        check_val("refill valid after reset", 0, refill_req_valid);
        @(posedge clk);
        miss_valid[1] <= 1'b1;
        miss_nline[1] <= 10'h2a5;
        miss_tid[1]   <= 2'd3;
        do @(negedge clk); while (!miss_ready[1]);
        @(posedge clk);
        miss_valid[1] <= 1'b0;
        take_mem_req(1, 10'h2a5, 2'd3, 5);
        repeat (4) begin
            @(negedge clk);
            check_val("no extra request", 0, mem_req_valid);
        end
        check_counts(0, 0, 0, 0, 0);
        end_test();

        start_test("two banks");
        @(posedge clk);
        miss_valid[0] <= 1'b1;
        miss_nline[0] <= 10'h011;
        miss_tid[0]   <= 2'd1;
        miss_valid[1] <= 1'b1;
        miss_nline[1] <= 10'h3c0;
        miss_tid[1]   <= 2'd2;
        @(negedge clk);
        check_val("bank 0 ready", 1, miss_ready[0]);
        check_val("bank 1 ready", 1, miss_ready[1]);
        @(posedge clk);
        miss_valid[0] <= 1'b0;
        miss_valid[1] <= 1'b0;
        take_mem_req(0, 10'h011, 2'd1, 0);
        take_mem_req(1, 10'h3c0, 2'd2, 0);
        check_counts(0, 0, 0, 0, 0);
        end_test();

        start_test("refill");
        send_refill(1, 2'd3, MEM_OK);
        wait_idle();
        check_counts(1, CHUNKS, 1, 0, 0);
        end_test();

        start_test("error refill");
        send_refill(0, 2'd1, MEM_NOK);
        wait_idle();
        check_counts(1, 0, 1, 0, 0);
        end_test();

        start_test("invalidation");
        send_inval(10'h155, 1'b1);
        wait_idle();
        send_inval(10'h0f0, 1'b0);
        wait_idle();
        check_counts(0, 0, 0, 2, 1);
        end_test();

        start_test("refill stall");
        @(posedge clk);
        refill_req_ready <= 1'b0;
        send_refill(0, 2'd2, MEM_OK);
        repeat (6) begin
            @(negedge clk);
            check_val("refill valid while stalled", 1, refill_req_valid);
            check_val("busy while stalled", 0, refill_busy);
        end
        check_val("mshr ack while stalled", 0, n_ack);
        check_val("data write while stalled", 0, n_wr);
        check_val("directory write while stalled", 0, n_dir);
        @(posedge clk);
        refill_req_ready <= 1'b1;
        wait_idle();
        check_counts(1, CHUNKS, 1, 0, 0);
        end_test();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 test_no, pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the reset time and the cycle budget per test
    initial begin
        #((RST_CYCLES + NTESTS * TEST_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* miss_handler.sv */
// Cache miss handler
`timescale 1ns/1ps
`default_nettype none

module miss_handler
    import cache_geom_pkg::*;
    import mem_proto_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  logic                      miss_req_valid_i [NBANKS],
    output logic                      miss_req_ready_o [NBANKS],
    input  nline_t                    miss_req_nline_i [NBANKS],
    input  tid_t                      miss_req_tid_i   [NBANKS],

    output logic                      mem_req_valid_o,
    input  logic                      mem_req_ready_i,
    output logic [MEM_ADDR_W-1:0]     mem_req_addr_o,
    output logic [$bits(MEM_LEN)-1:0] mem_req_len_o,
    output logic [MEM_ID_W-1:0]       mem_req_id_o,

    input  logic                      mem_rsp_valid_i,
    output logic                      mem_rsp_ready_o,
    input  logic [MEM_DATA_W-1:0]     mem_rsp_data_i,
    input  logic                      mem_rsp_last_i,
    input  mem_err_e                  mem_rsp_err_i,
    input  logic [MEM_ID_W-1:0]       mem_rsp_id_i,
    input  logic                      mem_rsp_inval_i,
    input  nline_t                    mem_rsp_inval_nline_i,

    output logic                      refill_req_valid_o,
    input  logic                      refill_req_ready_i,
    output logic                      refill_busy_o,
    output logic                      refill_is_error_o,
    output logic                      refill_write_data_o,
    output logic [MEM_DATA_W-1:0]     refill_data_o,
    output chunk_idx_t                refill_word_o,
    output logic                      refill_write_dir_o,

    output logic                      inval_check_dir_o,
    output nline_t                    inval_nline_o,
    input  logic                      inval_hit_i,
    output logic                      inval_write_dir_o,

    output logic                      mshr_ack_o    [NBANKS],
    output tid_t                      mshr_ack_id_o [NBANKS]
);

    rsp_buf_if i_rsp_buf ();

    miss_req_sender i_sender (
        .clk_i,
        .rst_ni,
        .miss_req_valid_i,
        .miss_req_ready_o,
        .miss_req_nline_i,
        .miss_req_tid_i,
        .mem_req_valid_o,
        .mem_req_ready_i,
        .mem_req_addr_o,
        .mem_req_len_o,
        .mem_req_id_o
    );

    refill_rsp_buffer i_rsp_buffer (
        .clk_i,
        .rst_ni,
        .mem_rsp_valid_i,
        .mem_rsp_ready_o,
        .mem_rsp_data_i,
        .mem_rsp_last_i,
        .mem_rsp_err_i,
        .mem_rsp_id_i,
        .mem_rsp_inval_i,
        .mem_rsp_inval_nline_i,
        .rsp_buf (i_rsp_buf.buffer)
    );

    refill_ctrl i_refill_ctrl (
        .clk_i,
        .rst_ni,
        .rsp_buf (i_rsp_buf.ctrl),
        .refill_req_valid_o,
        .refill_req_ready_i,
        .refill_busy_o,
        .refill_is_error_o,
        .refill_write_data_o,
        .refill_data_o,
        .refill_word_o,
        .refill_write_dir_o,
        .inval_check_dir_o,
        .inval_nline_o,
        .inval_hit_i,
        .inval_write_dir_o,
        .mshr_ack_o,
        .mshr_ack_id_o
    );

endmodule

`default_nettype wire

/* refill_ctrl.sv */
// Refill and invalidation controller
`timescale 1ns/1ps
`default_nettype none

module refill_ctrl
    import cache_geom_pkg::*;
    import mem_proto_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,

    rsp_buf_if.ctrl               rsp_buf,

    output logic                  refill_req_valid_o,
    input  logic                  refill_req_ready_i,
    output logic                  refill_busy_o,
    output logic                  refill_is_error_o,
    output logic                  refill_write_data_o,
    output logic [MEM_DATA_W-1:0] refill_data_o,
    output chunk_idx_t            refill_word_o,
    output logic                  refill_write_dir_o,

    output logic                  inval_check_dir_o,
    output nline_t                inval_nline_o,
    input  logic                  inval_hit_i,
    output logic                  inval_write_dir_o,

    output logic                  mshr_ack_o    [NBANKS],
    output tid_t                  mshr_ack_id_o [NBANKS]
);

    enum logic [1:0] {ST_IDLE, ST_WRITE, ST_INVAL} state_q, state_d;

    chunk_idx_t        cnt_q;
    chunk_idx_t        cnt_d;
    rsp_meta_entry_t   entry;
    logic [BANK_W-1:0] rsp_bank;
    tid_t              rsp_tid;

    assign entry    = rsp_buf.meta_entry;
    // The id carries the bank on top of the tid
    assign rsp_bank = entry.meta.refill.id[MEM_ID_W-1 -: BANK_W];
    assign rsp_tid  = entry.meta.refill.id[TID_W-1:0];

    assign refill_req_valid_o = (state_q == ST_IDLE) && rsp_buf.meta_valid;
    assign refill_busy_o      = (state_q != ST_IDLE);
    assign refill_is_error_o  = !entry.is_inval && (entry.meta.refill.err == MEM_NOK);
    assign refill_data_o      = rsp_buf.data_word;
    assign refill_word_o      = cnt_q;
    assign inval_nline_o      = entry.meta.inval.nline;

    always_comb begin
        state_d             = state_q;
        cnt_d               = cnt_q;
        refill_write_data_o = 1'b0;
        refill_write_dir_o  = 1'b0;
        inval_check_dir_o   = 1'b0;
        inval_write_dir_o   = 1'b0;
        rsp_buf.meta_pop    = 1'b0;
        rsp_buf.data_pop    = 1'b0;
        for (int unsigned b = 0; b < NBANKS; b++) begin
            mshr_ack_o[b]    = 1'b0;
            mshr_ack_id_o[b] = rsp_tid;
        end

        case (state_q)
            ST_IDLE: begin
                if (rsp_buf.meta_valid && refill_req_ready_i) begin
                    if (entry.is_inval) begin
                        inval_check_dir_o = 1'b1;
                        state_d           = ST_INVAL;
                    end else begin
                        mshr_ack_o[rsp_bank] = 1'b1;
                        cnt_d                = '0;
                        state_d              = ST_WRITE;
                    end
                end
            end
            ST_WRITE: begin
                // Error responses still drain the data but never write it
                refill_write_data_o = !refill_is_error_o;
                rsp_buf.data_pop    = 1'b1;
                cnt_d               = cnt_q + 1'b1;
                if (cnt_q == CHUNK_IDX_W'(CHUNKS - 1)) begin
                    refill_write_dir_o = 1'b1;
                    rsp_buf.meta_pop   = 1'b1;
                    state_d            = ST_IDLE;
                end
            end
            ST_INVAL: begin
                inval_write_dir_o = inval_hit_i;
                rsp_buf.meta_pop  = 1'b1;
                state_d           = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // Metadata for a refill is only queued after its last beat, so a data pop
    // under a refill entry always finds its beat buffered
    a_data_present: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_buf.data_pop |-> rsp_buf.meta_valid && !entry.is_inval);

endmodule

`default_nettype wire

/* refill_rsp_buffer.sv */
// Memory response buffer
`timescale 1ns/1ps
`default_nettype none

module refill_rsp_buffer
    import cache_geom_pkg::*;
    import mem_proto_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  mem_rsp_valid_i,
    output logic                  mem_rsp_ready_o,
    input  logic [MEM_DATA_W-1:0] mem_rsp_data_i,
    input  logic                  mem_rsp_last_i,
    input  mem_err_e              mem_rsp_err_i,
    input  logic [MEM_ID_W-1:0]   mem_rsp_id_i,
    input  logic                  mem_rsp_inval_i,
    input  nline_t                mem_rsp_inval_nline_i,

    rsp_buf_if.buffer             rsp_buf
);

    rsp_meta_entry_t meta_wdata;
    logic            meta_w;
    logic            meta_wok;
    logic            data_w;
    logic            data_wok;

    // Encode whichever record this beat carries
    always_comb begin
        meta_wdata          = '0;
        meta_wdata.is_inval = mem_rsp_inval_i;
        if (mem_rsp_inval_i) begin
            meta_wdata.meta.inval.nline = mem_rsp_inval_nline_i;
        end else begin
            meta_wdata.meta.refill.err = mem_rsp_err_i;
            meta_wdata.meta.refill.id  = mem_rsp_id_i;
        end
    end

    // Data beats only go to the data FIFO; the last one also needs a metadata slot
    assign data_w = mem_rsp_valid_i && !mem_rsp_inval_i && data_wok
                    && (meta_wok || !mem_rsp_last_i);

    assign meta_w = mem_rsp_valid_i && meta_wok
                    && (mem_rsp_inval_i || (mem_rsp_last_i && data_wok));

    always_comb begin
        mem_rsp_ready_o = 1'b0;
        if (mem_rsp_valid_i) begin
            if (mem_rsp_inval_i) begin
                mem_rsp_ready_o = meta_wok;
            end else begin
                mem_rsp_ready_o = data_wok && (meta_wok || !mem_rsp_last_i);
            end
        end
    end

    fifo_reg #(
        .DEPTH  (META_FIFO_DEPTH),
        .data_t (rsp_meta_entry_t)
    ) i_meta_fifo (
        .clk_i,
        .rst_ni,
        .w_i     (meta_w),
        .wok_o   (meta_wok),
        .wdata_i (meta_wdata),
        .r_i     (rsp_buf.meta_pop),
        .rok_o   (rsp_buf.meta_valid),
        .rdata_o (rsp_buf.meta_entry)
    );

    // Beat width equals the cache access width, so no resizing
    fifo_reg #(
        .DEPTH  (DATA_FIFO_DEPTH),
        .data_t (logic [MEM_DATA_W-1:0])
    ) i_data_fifo (
        .clk_i,
        .rst_ni,
        .w_i     (data_w),
        .wok_o   (data_wok),
        .wdata_i (mem_rsp_data_i),
        .r_i     (rsp_buf.data_pop),
        .rok_o   (),
        .rdata_o (rsp_buf.data_word)
    );

endmodule

`default_nettype wire

/* miss_req_sender.sv */
// Miss request sender
`timescale 1ns/1ps
`default_nettype none

module miss_req_sender
    import cache_geom_pkg::*;
    import mem_proto_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,

    input  logic                     miss_req_valid_i [NBANKS],
    output logic                     miss_req_ready_o [NBANKS],
    input  nline_t                   miss_req_nline_i [NBANKS],
    input  tid_t                     miss_req_tid_i   [NBANKS],

    output logic                     mem_req_valid_o,
    input  logic                     mem_req_ready_i,
    output logic [MEM_ADDR_W-1:0]    mem_req_addr_o,
    output logic [$bits(MEM_LEN)-1:0] mem_req_len_o,
    output logic [MEM_ID_W-1:0]      mem_req_id_o
);

    enum logic {SEND_IDLE, SEND_REQ} state_q, state_d;

    logic [NLINE_W+TID_W-1:0] miss_wdata [NBANKS];
    logic [NLINE_W+TID_W-1:0] miss_rdata [NBANKS];
    logic [NBANKS-1:0]        miss_rok;
    logic [NBANKS-1:0]        miss_grant;
    logic                     grant_any;
    logic [BANK_W-1:0]        grant_bank;
    logic [NLINE_W+TID_W-1:0] grant_entry;
    nline_t                   nline_q;
    logic [MEM_ID_W-1:0]      id_q;

    for (genvar b = 0; b < NBANKS; b++) begin : gen_bank
        assign miss_wdata[b] = {miss_req_nline_i[b], miss_req_tid_i[b]};

        fifo_reg #(
            .DEPTH  (MISS_FIFO_DEPTH),
            .data_t (logic [NLINE_W+TID_W-1:0])
        ) i_miss_fifo (
            .clk_i,
            .rst_ni,
            .w_i     (miss_req_valid_i[b] && miss_req_ready_o[b]),
            .wok_o   (miss_req_ready_o[b]),
            .wdata_i (miss_wdata[b]),
            .r_i     (miss_grant[b]),
            .rok_o   (miss_rok[b]),
            .rdata_o (miss_rdata[b])
        );
    end

    // Fixed priority, lowest bank wins, only while idle
    always_comb begin
        miss_grant  = '0;
        grant_any   = 1'b0;
        grant_bank  = '0;
        grant_entry = miss_rdata[0];
        if (state_q == SEND_IDLE) begin
            for (int unsigned b = 0; b < NBANKS; b++) begin
                if (miss_rok[b] && !grant_any) begin
                    miss_grant[b] = 1'b1;
                    grant_any     = 1'b1;
                    grant_bank    = BANK_W'(b);
                    grant_entry   = miss_rdata[b];
                end
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEND_IDLE: if (grant_any) state_d = SEND_REQ;
            SEND_REQ:  if (mem_req_ready_i) state_d = SEND_IDLE;
            default:   state_d = SEND_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= SEND_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request fields, captured when a bank is granted
    always_ff @(posedge clk_i) begin
        if (grant_any) begin
            nline_q <= grant_entry[NLINE_W+TID_W-1 -: NLINE_W];
            id_q    <= {grant_bank, grant_entry[TID_W-1:0]};
        end
    end

    assign mem_req_valid_o = (state_q == SEND_REQ);
    assign mem_req_addr_o  = {nline_q, {LINE_OFFSET_W{1'b0}}};
    assign mem_req_len_o   = MEM_LEN;
    assign mem_req_id_o    = id_q;

    a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_valid_o && !mem_req_ready_i |=>
            mem_req_valid_o && $stable(mem_req_addr_o) && $stable(mem_req_id_o));

endmodule

`default_nettype wire

/* fifo_reg.sv */
// Register FIFO
`timescale 1ns/1ps
`default_nettype none

module fifo_reg #(
    parameter int unsigned DEPTH = 2,
    parameter type data_t = logic
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  w_i,
    output logic  wok_o,
    input  data_t wdata_i,
    input  logic  r_i,
    output logic  rok_o,
    output data_t rdata_o
);

    data_t                      mem_q [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wptr_q;
    logic [$clog2(DEPTH)-1:0]   rptr_q;
    logic [$clog2(DEPTH+1)-1:0] count_q;

    assign wok_o = (count_q != ($clog2(DEPTH+1))'(DEPTH));
    assign rok_o = (count_q != '0);

    // Head entry is visible as long as the FIFO is not empty
    assign rdata_o = mem_q[rptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (w_i) begin
                wptr_q <= (wptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
            end
            if (r_i) begin
                rptr_q <= (rptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
            end
            if (w_i && !r_i) begin
                count_q <= count_q + 1'b1;
            end else if (r_i && !w_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (w_i) begin
            mem_q[wptr_q] <= wdata_i;
        end
    end

    a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_ni) w_i |-> wok_o);
    a_no_read_empty: assert property (@(posedge clk_i) disable iff (!rst_ni) r_i |-> rok_o);

endmodule

`default_nettype wire

/* rsp_buf_if.sv */
// Response buffer link
`timescale 1ns/1ps
`default_nettype none

interface rsp_buf_if
    import mem_proto_pkg::*;
();

    logic                  meta_valid;
    rsp_meta_entry_t       meta_entry;
    logic                  meta_pop;
    logic [MEM_DATA_W-1:0] data_word;
    logic                  data_pop;

    modport buffer (
        output meta_valid, meta_entry, data_word,
        input  meta_pop, data_pop
    );

    modport ctrl (
        input  meta_valid, meta_entry, data_word,
        output meta_pop, data_pop
    );

endinterface

`default_nettype wire

/* mem_proto_pkg.sv */
// Memory protocol definitions
`default_nettype none

package mem_proto_pkg;

    import cache_geom_pkg::*;

    localparam int unsigned MEM_DATA_W = 64;
    localparam int unsigned MEM_ID_W = BANK_W + TID_W;
    localparam int unsigned MEM_ADDR_W = NLINE_W + LINE_OFFSET_W;

    // Burst length field, beats minus one
    localparam logic [1:0] MEM_LEN = 2'd3;

    localparam int unsigned META_FIFO_DEPTH = 2;
    localparam int unsigned DATA_FIFO_DEPTH = 8;

    // Width of the shared metadata word
    localparam int unsigned META_W = 13;

    typedef enum logic {
        MEM_OK  = 1'b0,
        MEM_NOK = 1'b1
    } mem_err_e;

    // One metadata word, read as a refill or as an invalidation
    typedef union packed {
        struct packed {
            mem_err_e                      err;
            logic [MEM_ID_W-1:0]           id;
            logic [META_W-MEM_ID_W-2:0]    pad;
        } refill;
        struct packed {
            nline_t                        nline;
            logic [META_W-NLINE_W-1:0]     pad;
        } inval;
    } rsp_meta_u;

    typedef struct packed {
        logic      is_inval;
        rsp_meta_u meta;
    } rsp_meta_entry_t;

endpackage

`default_nettype wire

/* cache_geom_pkg.sv */
// Cache geometry definitions
`default_nettype none

package cache_geom_pkg;

    // Banks of the data cache
    localparam int unsigned NBANKS = 2;
    localparam int unsigned BANK_W = 1;

    // Transaction id, also used as the MSHR id
    localparam int unsigned TID_W = 2;

    // Line addressing, 32-byte lines
    localparam int unsigned NLINE_W = 10;
    localparam int unsigned LINE_OFFSET_W = 5;

    // A line is refilled in four chunks
    localparam int unsigned CHUNKS = 4;
    localparam int unsigned CHUNK_IDX_W = 2;

    localparam int unsigned MISS_FIFO_DEPTH = 2;

    typedef logic [NLINE_W-1:0] nline_t;
    typedef logic [TID_W-1:0] tid_t;
    typedef logic [CHUNK_IDX_W-1:0] chunk_idx_t;

endpackage

`default_nettype wire
